/* logic/mic_level_pkg.sv */
package mic_level_pkg;

    // --------------------
    // sample format

    localparam int w_sample      = 24;  // signed two's complement
    localparam int bits_per_slot = 32;  // sck periods per ws half

    // --------------------
    // receiver slot tracking

    typedef enum logic
    {
        rx_left_slot,                   // ws low
        rx_right_slot                   // ws high, not captured
    } rx_state_t;

    // --------------------
    // meter mode

    typedef enum logic
    {
        meter_run,
        meter_hold                      // display frozen
    } meter_state_t;

endpackage

/* logic/sample_fifo_if.sv */
`timescale 1ns/1ps

interface sample_fifo_if
#(
    parameter int w_sample = mic_level_pkg::w_sample
);

    logic                  push;        // one-cycle strobe
    logic [w_sample - 1:0] push_data;
    logic                  full;

    logic                  pop;         // only while empty is low
    logic [w_sample - 1:0] pop_data;    // show-ahead
    logic                  empty;

    modport writer
    (
        output push, push_data,
        input  full
    );

    modport buffer
    (
        input  push, push_data, pop,
        output full, empty, pop_data
    );

    modport reader
    (
        output pop,
        input  pop_data, empty
    );

endinterface

/* logic/inmp441_mic_i2s_receiver.sv */
`timescale 1ns/1ps

module inmp441_mic_i2s_receiver
#(
    parameter int sck_half = 4
)
(
    input  logic          clk,
    input  logic          rst_n,

    output logic          sck,
    output logic          ws,
    input  logic          sd,

    sample_fifo_if.writer fifo
);

    localparam int w_div     = sck_half > 1 ? $clog2(sck_half) : 1;
    localparam int w_bit     = $clog2(mic_level_pkg::bits_per_slot);
    localparam int first_bit = 1;                          // 2nd rising edge in slot
    localparam int last_bit  = mic_level_pkg::w_sample;    // 25th rising edge

    logic [w_div - 1:0]                  div_cnt;
    logic                                tick;
    logic                                sck_rise;
    logic                                sck_fall;
    logic [w_bit - 1:0]                  bit_cnt;      // falling edges seen in slot
    mic_level_pkg::rx_state_t            state;
    logic                                in_window;
    logic [mic_level_pkg::w_sample - 1:0] shift_reg;

    assign tick     = (div_cnt == w_div'(sck_half - 1));
    assign sck_rise = tick & ~sck;
    assign sck_fall = tick &  sck;

    // --------------------
    // bit clock

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (tick)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;

    // --------------------
    // slot counter, ws changes on sck fall

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
        begin
            bit_cnt <= '0;
            state   <= mic_level_pkg::rx_left_slot;
        end
        else if (sck_fall)
        begin
            if (bit_cnt == w_bit'(mic_level_pkg::bits_per_slot - 1))
            begin
                bit_cnt <= '0;
                state   <= (state == mic_level_pkg::rx_left_slot)
                         ? mic_level_pkg::rx_right_slot
                         : mic_level_pkg::rx_left_slot;
            end
            else
                bit_cnt <= bit_cnt + 1'b1;
        end

    assign ws = (state == mic_level_pkg::rx_right_slot);    // low for left

    // --------------------
    // capture and push

    assign in_window = (state == mic_level_pkg::rx_left_slot)
                     && (bit_cnt >= w_bit'(first_bit))
                     && (bit_cnt <= w_bit'(last_bit));

    always_ff @(posedge clk)
        if (sck_rise && in_window)
            shift_reg <= {shift_reg[mic_level_pkg::w_sample - 2:0], sd};  // msb first

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
            fifo.push <= 1'b0;
        else
            fifo.push <= sck_rise
                       && (state == mic_level_pkg::rx_left_slot)
                       && (bit_cnt == w_bit'(last_bit));    // never stalled by full

    assign fifo.push_data = shift_reg;

endmodule

/* logic/sample_fifo.sv */
`timescale 1ns/1ps

module sample_fifo
#(
    parameter int fifo_depth = 4
)
(
    input  logic          clk,
    input  logic          rst_n,
    sample_fifo_if.buffer fifo,
    output logic          overflow
);

    localparam int w_ptr = fifo_depth > 1 ? $clog2(fifo_depth) : 1;
    localparam int w_cnt = $clog2(fifo_depth + 1);

    logic [mic_level_pkg::w_sample - 1:0] mem [fifo_depth];
    logic [w_ptr - 1:0]                   wr_ptr;
    logic [w_ptr - 1:0]                   rd_ptr;
    logic [w_cnt - 1:0]                   count;
    logic                                 wr_en;
    logic                                 rd_en;

    function automatic logic [w_ptr - 1:0] ptr_next(input logic [w_ptr - 1:0] ptr);
        return (ptr == w_ptr'(fifo_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fifo.full     = (count == w_cnt'(fifo_depth));
    assign fifo.empty    = (count == '0);
    assign fifo.pop_data = mem[rd_ptr];    // head word, show-ahead

    assign wr_en = fifo.push & ~fifo.full;  // push while full is dropped
    assign rd_en = fifo.pop  & ~fifo.empty;

    always_ff @(posedge clk)
        if (wr_en)
            mem[wr_ptr] <= fifo.push_data;

    // --------------------
    // pointers and occupancy

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr <= ptr_next(wr_ptr);
            if (rd_en)
                rd_ptr <= ptr_next(rd_ptr);

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
            overflow <= 1'b0;
        else if (fifo.push && fifo.full)
            overflow <= 1'b1;               // sticky until reset

endmodule

/* logic/peak_level_meter.sv */
`timescale 1ns/1ps

module peak_level_meter
#(
    parameter int window_len = 4,
    parameter int w_led      = 6
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               hold,
    sample_fifo_if.reader      fifo,
    output logic [w_led - 1:0] level
);

    localparam int w_sample = mic_level_pkg::w_sample;
    localparam int w_mag    = w_sample - 1;
    localparam int w_win    = window_len > 1 ? $clog2(window_len) : 1;
    localparam int thr_base = w_sample - 1 - w_led;     // lowest led threshold exponent

    mic_level_pkg::meter_state_t state;
    logic [w_sample - 1:0]       neg_data;
    logic [w_mag - 1:0]          mag;
    logic [w_mag - 1:0]          peak;
    logic [w_win - 1:0]          win_cnt;
    logic                        window_done;
    logic [w_led - 1:0]          bar;

    // --------------------
    // saturated magnitude

    assign neg_data = ~fifo.pop_data + 1'b1;

    always_comb
        if (!fifo.pop_data[w_sample - 1])
            mag = fifo.pop_data[w_mag - 1:0];
        else if (fifo.pop_data[w_mag - 1:0] == '0)
            mag = '1;                                   // most negative value
        else
            mag = neg_data[w_mag - 1:0];

    // thermometer from the window peak
    for (genvar i = 0; i < w_led; i++)
    begin : g_bar
        assign bar[i] = (peak >= (w_mag'(1) << (thr_base + i)));
    end

    // --------------------
    // run / hold and pop

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
            state <= mic_level_pkg::meter_run;
        else
            state <= hold ? mic_level_pkg::meter_hold : mic_level_pkg::meter_run;

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
            fifo.pop <= 1'b0;
        else
            fifo.pop <= (state == mic_level_pkg::meter_run)
                      && !hold                      // no pop once hold is requested
                      && !fifo.empty
                      && !fifo.pop;                 // let empty settle after a pop

    // --------------------
    // window peak and level

    always_ff @(posedge clk or negedge rst_n)
        if (!rst_n)
        begin
            win_cnt     <= '0;
            peak        <= '0;
            window_done <= 1'b0;
            level       <= '0;
        end
        else if (fifo.pop)
        begin
            if (mag > peak)
                peak <= mag;

            if (win_cnt == w_win'(window_len - 1))
            begin
                win_cnt     <= '0;
                window_done <= 1'b1;
            end
            else
                win_cnt <= win_cnt + 1'b1;
        end
        else if (window_done && state == mic_level_pkg::meter_run)
        begin
            level       <= bar;                 // frozen while held
            peak        <= '0;
            window_done <= 1'b0;
        end

endmodule

/* logic/board_specific_top.sv */
`timescale 1ns/1ps

module board_specific_top
#(
    parameter int sck_half   = 4,
    parameter int fifo_depth = 4,
    parameter int window_len = 4,
    parameter int w_led      = 6,
    parameter int w_key      = 2
)
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic               pll_lock,

    input  logic [w_key - 1:0] key,         // active low

    output logic               mic_sck,
    output logic               mic_ws,
    input  logic               mic_sd,

    output logic [w_led - 1:0] led,         // active low
    output logic               overflow
);

    logic               rst_gate_n;
    logic [1:0]         rst_sync;
    logic               sys_rst_n;
    logic               hold;
    logic [w_led - 1:0] level;

    sample_fifo_if #(.w_sample (mic_level_pkg::w_sample)) fifo_bus ();

    // --------------------
    // reset gating with pll lock

    assign rst_gate_n = rst_n & pll_lock;

    always_ff @(posedge clk or negedge rst_gate_n)
        if (!rst_gate_n)
            rst_sync <= 2'b00;
        else
            rst_sync <= {rst_sync[0], 1'b1};    // release after two clocks

    assign sys_rst_n = rst_sync[1];

    assign hold = ~key[0];
    assign led  = ~level;

    // --------------------

    inmp441_mic_i2s_receiver
    # (
        .sck_half ( sck_half  )
    )
    i_receiver
    (
        .clk      ( clk       ),
        .rst_n    ( sys_rst_n ),
        .sck      ( mic_sck   ),
        .ws       ( mic_ws    ),
        .sd       ( mic_sd    ),
        .fifo     ( fifo_bus  )
    );

    sample_fifo
    # (
        .fifo_depth ( fifo_depth )
    )
    i_fifo
    (
        .clk        ( clk        ),
        .rst_n      ( sys_rst_n  ),
        .fifo       ( fifo_bus   ),
        .overflow   ( overflow   )
    );

    peak_level_meter
    # (
        .window_len ( window_len ),
        .w_led      ( w_led      )
    )
    i_meter
    (
        .clk        ( clk        ),
        .rst_n      ( sys_rst_n  ),
        .hold       ( hold       ),
        .fifo       ( fifo_bus   ),
        .level      ( level      )
    );

endmodule

/* sim/tb_board_specific_top.sv */
`timescale 1ns/1ps

module tb_board_specific_top;

    localparam int n_rows        = 30;
    localparam int frame_timeout = 600;         // clocks, one frame is 512
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic       clk;
    logic       rst_n;
    logic       pll_lock;
    logic [1:0] key;
    logic       mic_sck;
    logic       mic_ws;
    logic       mic_sd = 1'b0;
    logic [5:0] led;
    logic       overflow;

    logic [23:0] stim [0:4 * n_rows - 1];       // sample, hold, bar, overflow
    logic [31:0] lfsr = 32'd94464;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    // frame format monitor state
    logic monitor_on = 1'b0;
    logic sck_seen = 1'b0;
    logic ws_seen = 1'b0;
    logic seen_toggle = 1'b0;
    int   half_cnt = 0;
    int   rise_cnt = 0;

    // reference model of fifo and meter
    logic [22:0] q [$];
    logic [22:0] win_peak = '0;
    int          win_n = 0;
    logic [5:0]  model_bar = '0;
    logic        model_ovf = 1'b0;

    board_specific_top u_board_specific_top
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pll_lock ( pll_lock ),
        .key      ( key      ),
        .mic_sck  ( mic_sck  ),
        .mic_ws   ( mic_ws   ),
        .mic_sd   ( mic_sd   ),
        .led      ( led      ),
        .overflow ( overflow )
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // --------------------
    // helpers

    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ lfsr_taps;
        return b;
    endfunction

    function automatic logic [22:0] magnitude(input logic [23:0] s);
        logic [23:0] n;
        n = -s;
        if (s == 24'h80_0000)
            return 23'h7F_FFFF;                 // saturate full-scale negative
        return s[23] ? n[22:0] : s[22:0];
    endfunction

    function automatic logic [5:0] bar_of(input logic [22:0] peak);
        logic [5:0] b;
        for (int i = 0; i < 6; i++)
            b[i] = (peak >= 23'(1 << (17 + i)));
        return b;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout while waiting for %s", what);
        errors++;
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before)
            $display("test %s: pass", name);
        else
        begin
            tests_failed++;
            $display("test %s: fail, %0d errors", name, errors - err_before);
        end
    endtask

    task automatic watch_frame_format();
        if (monitor_on)
        begin
            half_cnt++;
            if (mic_sck != sck_seen)
            begin
                if (seen_toggle)
                begin
                    assert (half_cnt == 4)
                    else
                    begin
                        $display("FAIL t=%0t mic_sck half period expected 4 got %0d",
                                 $time, half_cnt);
                        errors++;
                    end
                end
                seen_toggle = 1'b1;
                half_cnt    = 0;
                if (mic_sck)
                    rise_cnt++;
            end
            if (mic_ws != ws_seen)
            begin
                assert (rise_cnt == 32)
                else
                begin
                    $display("FAIL t=%0t mic_ws slot length expected 32 got %0d",
                             $time, rise_cnt);
                    errors++;
                end
                rise_cnt = 0;
            end
        end
        sck_seen = mic_sck;
        ws_seen  = mic_ws;
    endtask

    task automatic wait_frame_end(output logic ok);
        int   n;
        logic fell;
        n    = 0;
        fell = 1'b0;
        while (!fell && n < frame_timeout)
        begin
            @(negedge clk);
            n++;
            fell = ws_seen && !mic_ws;
            watch_frame_format();
        end
        if (!fell)
            report_timeout("the start of the next frame");
        ok = fell;
    endtask

    task automatic model_row(input int r);
        logic [22:0] m;
        m = magnitude(stim[4 * r]);
        if (stim[4 * r + 1][0] && q.size() >= 4)
            model_ovf = 1'b1;                   // dropped while full
        else
            q.push_back(m);
        while (!stim[4 * r + 1][0] && q.size() > 0)
        begin
            m = q.pop_front();
            if (m > win_peak)
                win_peak = m;
            win_n++;
            if (win_n == 4)
            begin
                model_bar = bar_of(win_peak);
                win_peak  = '0;
                win_n     = 0;
            end
        end
    endtask

    // --------------------
    // microphone model, drives sd after each sck fall

    logic m_sck = 1'b0;
    logic m_ws = 1'b0;
    int   bit_idx = 0;
    int   cur_row = 0;

    always @(negedge clk)
        if (!rst_n || !pll_lock)
        begin
            m_sck   = 1'b0;
            m_ws    = 1'b0;
            bit_idx = 0;
            cur_row = 0;
            mic_sd  = 1'b0;
        end
        else
        begin
            if (m_sck && !mic_sck)
            begin
                if (mic_ws)
                    mic_sd = lfsr_bit();        // right slot noise
                else if (m_ws)
                begin
                    cur_row++;                  // new left slot
                    bit_idx = 0;
                    mic_sd  = 1'b0;
                end
                else if (bit_idx < 24 && cur_row < n_rows)
                begin
                    mic_sd = stim[4 * cur_row][23 - bit_idx];   // msb first
                    bit_idx++;
                end
                else
                    mic_sd = 1'b0;
                m_ws = mic_ws;
            end
            m_sck = mic_sck;
        end

    // --------------------
    // main sequence

    initial
    begin
        int   err_mark;
        logic frame_ok;
        logic timed_out;
        timed_out = 1'b0;
        $readmemh("sim/mic_stimulus.txt", stim);
        rst_n    = 1'b0;
        pll_lock = 1'b0;
        key      = 2'b11;
        key[0]   = ~stim[1][0];
        repeat (2) @(negedge clk);
        rst_n    = 1'b1;
        pll_lock = 1'b1;

        err_mark = errors;
        repeat (3) @(negedge clk);
        assert (led == 6'h3F && overflow == 1'b0 && mic_ws == 1'b0 && mic_sck == 1'b0)
        else
        begin
            $display("FAIL t=%0t led/overflow/mic_ws/mic_sck expected 3f/0/0/0 got %h/%b/%b/%b",
                     $time, led, overflow, mic_ws, mic_sck);
            errors++;
        end
        report_test("reset state", err_mark);

        monitor_on = 1'b1;
        err_mark   = errors;
        for (int r = 0; r < n_rows; r++)
        begin
            wait_frame_end(frame_ok);
            if (!frame_ok)
            begin
                timed_out = 1'b1;
                break;
            end
            model_row(r);
            assert (led == ~model_bar)
            else
            begin
                $display("FAIL t=%0t led expected %h got %h", $time, ~model_bar, led);
                errors++;
            end
            assert (overflow == model_ovf)
            else
            begin
                $display("FAIL t=%0t overflow expected %b got %b", $time, model_ovf, overflow);
                errors++;
            end
            assert (stim[4 * r + 2][5:0] == model_bar && stim[4 * r + 3][0] == model_ovf)
            else
            begin
                $display("stimulus row %0d disagrees with the reference model", r);
                errors++;
            end
            if (r + 1 < n_rows)
                key[0] = ~stim[4 * (r + 1) + 1][0];
            if (r == 1)
            begin
                monitor_on = 1'b0;
                report_test("frame format", err_mark);
                err_mark = errors;
            end
            if (r == 15 || r == 21 || r == 29)
            begin
                report_test(r == 15 ? "peak windows" : r == 21 ? "hold and overflow"
                          : "resume after hold", err_mark);
                err_mark = errors;
            end
        end

        if (!timed_out)
        begin
            pll_lock = 1'b0;                    // lock lost, async reset
            @(negedge clk);
            assert (led == 6'h3F && overflow == 1'b0)
            else
            begin
                $display("FAIL t=%0t led/overflow expected 3f/0 got %h/%b",
                         $time, led, overflow);
                errors++;
            end
            pll_lock = 1'b1;
            report_test("pll loss", err_mark);
        end

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* sim/mic_stimulus.txt */
// columns: sample (24-bit hex), hold flag, expected bar (active high), expected overflow
// one row per microphone frame, bars hold the level after that frame
000100 0 00 0
FFFF00 0 00 0
01FFFF 0 00 0
FE0001 0 00 0
800000 0 00 0
000010 0 00 0
123456 0 00 0
FFFFFF 0 3F 0
020000 0 3F 0
FC0000 0 3F 0
080000 0 3F 0
001000 0 07 0
000000 0 07 0
F00000 0 07 0
0FFFFF 0 07 0
000001 0 0F 0
400000 1 0F 0
000050 1 0F 0
000060 1 0F 0
000070 1 0F 0
7FFFFF 1 0F 1
800000 1 0F 1
000200 0 3F 1
FFFE00 0 3F 1
000300 0 3F 1
00FFFF 0 00 1
200000 0 00 1
000000 0 00 1
DFFFFF 0 00 1
000001 0 1F 1

/* board_specific_top.f */
logic/mic_level_pkg.sv
logic/sample_fifo_if.sv
logic/inmp441_mic_i2s_receiver.sv
logic/sample_fifo.sv
logic/peak_level_meter.sv
logic/board_specific_top.sv
sim/tb_board_specific_top.sv

/* Makefile */
# Verilator build and run for the microphone level meter

VERILATOR ?= verilator
TOP       ?= tb_board_specific_top
FILELIST  ?= board_specific_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
